// ==== logic/l15_pkg.sv ====
package l15_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// 64-bit L1.5 data word taken whole or as two 32-bit words
	typedef union packed
	{
		logic [63:0] raw;
		word_t [1:0] halves;    // Index 0 is the lower word
	} l15_word_t;

	// Request types driven toward the L1.5
	localparam logic [4:0] rqtype_load = 5'b00000;
	localparam logic [4:0] rqtype_store = 5'b00001;

	// Return types coming back
	localparam logic [3:0] rtype_load = 4'b0000;
	localparam logic [3:0] rtype_store_ack = 4'b0100;

	localparam logic [2:0] size_word = 3'b010;  // 4 bytes

	// Port ownership
	typedef enum logic [1:0]
	{
		arb_instr = 2'd0,
		arb_wait = 2'd1,
		arb_mem = 2'd2
	} arb_state_t;

endpackage

// ==== logic/l15_arbiter.sv ====
module l15_arbiter
(
	input  logic clk,
	input  logic nrst,
	input  logic mem_pending,
	input  logic mem_done,
	input  logic fetch_busy,
	output l15_pkg::arb_state_t owner,
	output logic fetch_stall
);
	import l15_pkg::*;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			owner <= arb_instr;
		else
		begin
			case (owner)
				arb_instr:
				begin
					// Data memory asked for the port
					if (mem_pending)
						owner <= arb_wait;
				end
				arb_wait:
				begin
					// Hand over once fetch has nothing in flight
					if (!fetch_busy)
						owner <= arb_mem;
				end
				arb_mem:
				begin
					if (mem_done && !mem_pending)
						owner <= arb_instr;
				end
				default:
					owner <= arb_instr;
			endcase
		end
	end

	// Fetch may only start a request while it owns the port and no
	// memory operation is waiting for it
	assign fetch_stall = (owner != arb_instr) || mem_pending;

endmodule

// ==== logic/l15_port_mux.sv ====
module l15_port_mux
(
	input  l15_pkg::arb_state_t owner,

	// Fetch side
	input  logic [4:0] f_rqtype,
	input  logic [2:0] f_size,
	input  l15_pkg::addr_t f_address,
	input  logic f_val,
	output logic f_header_ack,
	output logic f_rsp_val,
	input  logic f_req_ack,

	// Data memory side
	input  logic [4:0] m_rqtype,
	input  logic [2:0] m_size,
	input  l15_pkg::addr_t m_address,
	input  logic [63:0] m_data,
	input  logic m_val,
	output logic m_header_ack,
	output logic m_rsp_val,
	input  logic m_req_ack,

	// Outside L1.5 port
	output logic [4:0] transducer_l15_rqtype,
	output logic [2:0] transducer_l15_size,
	output l15_pkg::addr_t transducer_l15_address,
	output logic [63:0] transducer_l15_data,
	output logic transducer_l15_val,
	input  logic l15_transducer_header_ack,
	input  logic l15_transducer_val,
	output logic transducer_l15_req_ack
);
	import l15_pkg::*;

	always_comb
	begin
		// Fetch fields by default with every handshake closed
		transducer_l15_rqtype = f_rqtype;
		transducer_l15_size = f_size;
		transducer_l15_address = f_address;
		transducer_l15_data = '0;         // Fetch never writes
		transducer_l15_val = 1'b0;
		transducer_l15_req_ack = 1'b0;
		f_header_ack = 1'b0;
		f_rsp_val = 1'b0;
		m_header_ack = 1'b0;
		m_rsp_val = 1'b0;

		case (owner)
			// In arb_wait the fetch stall is up so only a request already
			// on the port can finish and its response still goes to fetch
			arb_instr, arb_wait:
			begin
				transducer_l15_val = f_val;
				f_header_ack = l15_transducer_header_ack;
				f_rsp_val = l15_transducer_val;
				transducer_l15_req_ack = f_req_ack;
			end
			arb_mem:
			begin
				transducer_l15_rqtype = m_rqtype;
				transducer_l15_size = m_size;
				transducer_l15_address = m_address;
				transducer_l15_data = m_data;
				transducer_l15_val = m_val;
				m_header_ack = l15_transducer_header_ack;
				m_rsp_val = l15_transducer_val;
				transducer_l15_req_ack = m_req_ack;
			end
			default:
			begin
				transducer_l15_val = 1'b0;  // Unused encoding keeps the port closed
			end
		endcase
	end

endmodule

// ==== logic/fetch_unit.sv ====
module fetch_unit
#(
	parameter l15_pkg::addr_t reset_pc = 32'h0000_0000
)
(
	input  logic clk,
	input  logic nrst,
	input  logic fetch_stall,

	// L1.5 request
	output logic [4:0] rqtype,
	output logic [2:0] size,
	output l15_pkg::addr_t address,
	output logic val,
	input  logic header_ack,

	// L1.5 response
	input  logic rsp_val,
	input  l15_pkg::l15_word_t rsp_data,
	output logic req_ack,

	output logic fetch_busy,

	// Instruction output
	output l15_pkg::word_t instr,
	output l15_pkg::addr_t instr_pc,
	output logic instr_valid,
	input  logic instr_ready
);
	import l15_pkg::*;

	localparam logic [1:0] s_idle = 2'd0;
	localparam logic [1:0] s_req = 2'd1;
	localparam logic [1:0] s_rsp = 2'd2;

	logic [1:0] state;
	addr_t pc;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= s_idle;
			val <= 1'b0;
			instr_valid <= 1'b0;
			pc <= reset_pc;
		end
		else
		begin
			// Next sequential word once the buffer drains
			if (instr_valid && instr_ready)
			begin
				instr_valid <= 1'b0;
				pc <= pc + 32'd4;
			end

			case (state)
				s_idle:
				begin
					if (!fetch_stall && !instr_valid)
					begin
						val <= 1'b1;
						state <= s_req;
					end
				end
				s_req:
				begin
					if (header_ack)
					begin
						val <= 1'b0;
						state <= s_rsp;
					end
				end
				s_rsp:
				begin
					if (req_ack)
					begin
						instr_valid <= 1'b1;
						state <= s_idle;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	// Instruction buffer
	always_ff @(posedge clk)
	begin
		if (req_ack)
			instr <= rsp_data.halves[pc[2]];
	end

	assign req_ack = rsp_val && (state == s_rsp);  // Buffer is empty in s_rsp
	assign fetch_busy = (state != s_idle);

	assign rqtype = rqtype_load;
	assign size = size_word;
	assign address = pc;
	assign instr_pc = pc;    // pc only moves on transfer

endmodule

// ==== logic/mem_unit.sv ====
module mem_unit
(
	input  logic clk,
	input  logic nrst,

	// Command and response
	input  logic mem_cmd_valid,
	output logic mem_cmd_ready,
	input  logic mem_cmd_store,
	input  l15_pkg::addr_t mem_cmd_addr,
	input  l15_pkg::word_t mem_cmd_wdata,
	output logic mem_rsp_valid,
	output l15_pkg::word_t mem_rsp_data,
	output logic mem_rsp_misaligned,

	// L1.5 request
	output logic [4:0] rqtype,
	output logic [2:0] size,
	output l15_pkg::addr_t address,
	output logic [63:0] data,
	output logic val,
	input  logic header_ack,

	// L1.5 response
	input  logic rsp_val,
	input  l15_pkg::l15_word_t rsp_data,
	input  logic [3:0] rsp_returntype,
	output logic req_ack,

	output logic mem_pending,
	output logic mem_done,
	input  logic grant
);
	import l15_pkg::*;

	localparam logic [2:0] s_idle = 3'd0;
	localparam logic [2:0] s_misal = 3'd1;
	localparam logic [2:0] s_grant = 3'd2;
	localparam logic [2:0] s_req = 3'd3;
	localparam logic [2:0] s_rsp = 3'd4;

	logic [2:0] state;
	logic is_store;
	addr_t addr;
	word_t wdata;
	logic cmd_fire;
	logic cmd_misaligned;
	logic rsp_match;

	assign cmd_fire = mem_cmd_valid && mem_cmd_ready;
	assign cmd_misaligned = (mem_cmd_addr[1:0] != 2'b00);

	// Only the return type of the issued request completes it
	assign rsp_match = rsp_val &&
		(rsp_returntype == (is_store ? rtype_store_ack : rtype_load));

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= s_idle;
			mem_cmd_ready <= 1'b0;
			val <= 1'b0;
			mem_rsp_valid <= 1'b0;
		end
		else
		begin
			mem_rsp_valid <= 1'b0;
			case (state)
				s_idle:
				begin
					if (cmd_fire)
					begin
						mem_cmd_ready <= 1'b0;
						state <= cmd_misaligned ? s_misal : s_grant;
					end
					else
						mem_cmd_ready <= 1'b1;
				end
				s_misal:
				begin
					mem_rsp_valid <= 1'b1;  // Answered without the port
					state <= s_idle;
				end
				s_grant:
				begin
					if (grant)
					begin
						val <= 1'b1;
						state <= s_req;
					end
				end
				s_req:
				begin
					if (header_ack)
					begin
						val <= 1'b0;
						state <= s_rsp;
					end
				end
				s_rsp:
				begin
					if (rsp_match)
					begin
						mem_rsp_valid <= 1'b1;
						state <= s_idle;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_fire)
		begin
			is_store <= mem_cmd_store;
			addr <= mem_cmd_addr;
			wdata <= mem_cmd_wdata;
			mem_rsp_misaligned <= cmd_misaligned;
		end
		if ((state == s_rsp) && rsp_match && !is_store)
			mem_rsp_data <= rsp_data.halves[addr[2]];
	end

	assign mem_pending = (state == s_grant) || (state == s_req) || (state == s_rsp);
	assign mem_done = mem_rsp_valid && !mem_rsp_misaligned;
	assign req_ack = rsp_val;     // Always able to take a response

	assign rqtype = is_store ? rqtype_store : rqtype_load;
	assign size = size_word;
	assign address = addr;
	assign data = {wdata, wdata};  // Same word in both halves

endmodule

// ==== logic/core_mem_port.sv ====
module core_mem_port
#(
	parameter l15_pkg::addr_t reset_pc = 32'h0000_0200
)
(
	input  logic clk,
	input  logic nrst,

	// L1.5 request
	output logic [4:0] transducer_l15_rqtype,
	output logic [2:0] transducer_l15_size,
	output l15_pkg::addr_t transducer_l15_address,
	output logic [63:0] transducer_l15_data,
	output logic transducer_l15_val,
	input  logic l15_transducer_header_ack,

	// L1.5 response
	input  logic l15_transducer_val,
	input  logic [63:0] l15_transducer_data_0,
	input  logic [3:0] l15_transducer_returntype,
	output logic transducer_l15_req_ack,

	// Instruction stream
	output l15_pkg::word_t instr,
	output l15_pkg::addr_t instr_pc,
	output logic instr_valid,
	input  logic instr_ready,

	// Data memory commands
	input  logic mem_cmd_valid,
	output logic mem_cmd_ready,
	input  logic mem_cmd_store,
	input  l15_pkg::addr_t mem_cmd_addr,
	input  l15_pkg::word_t mem_cmd_wdata,
	output logic mem_rsp_valid,
	output l15_pkg::word_t mem_rsp_data,
	output logic mem_rsp_misaligned
);
	import l15_pkg::*;

	arb_state_t owner;
	logic fetch_stall;
	logic fetch_busy;
	logic mem_pending;
	logic mem_done;
	logic grant;

	logic [4:0] f_rqtype;
	logic [2:0] f_size;
	addr_t f_address;
	logic f_val;
	logic f_header_ack;
	logic f_rsp_val;
	logic f_req_ack;

	logic [4:0] m_rqtype;
	logic [2:0] m_size;
	addr_t m_address;
	logic [63:0] m_data;
	logic m_val;
	logic m_header_ack;
	logic m_rsp_val;
	logic m_req_ack;

	assign grant = (owner == arb_mem);

	l15_arbiter arbiter_i
	(
		.clk         (clk),
		.nrst        (nrst),
		.mem_pending (mem_pending),
		.mem_done    (mem_done),
		.fetch_busy  (fetch_busy),
		.owner       (owner),
		.fetch_stall (fetch_stall)
	);

	l15_port_mux port_mux_i
	(
		.owner                     (owner),
		.f_rqtype                  (f_rqtype),
		.f_size                    (f_size),
		.f_address                 (f_address),
		.f_val                     (f_val),
		.f_header_ack              (f_header_ack),
		.f_rsp_val                 (f_rsp_val),
		.f_req_ack                 (f_req_ack),
		.m_rqtype                  (m_rqtype),
		.m_size                    (m_size),
		.m_address                 (m_address),
		.m_data                    (m_data),
		.m_val                     (m_val),
		.m_header_ack              (m_header_ack),
		.m_rsp_val                 (m_rsp_val),
		.m_req_ack                 (m_req_ack),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_val        (l15_transducer_val),
		.transducer_l15_req_ack    (transducer_l15_req_ack)
	);

	fetch_unit #(.reset_pc(reset_pc)) fetch_i
	(
		.clk         (clk),
		.nrst        (nrst),
		.fetch_stall (fetch_stall),
		.rqtype      (f_rqtype),
		.size        (f_size),
		.address     (f_address),
		.val         (f_val),
		.header_ack  (f_header_ack),
		.rsp_val     (f_rsp_val),
		.rsp_data    (l15_transducer_data_0),
		.req_ack     (f_req_ack),
		.fetch_busy  (fetch_busy),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready)
	);

	mem_unit mem_i
	(
		.clk                (clk),
		.nrst               (nrst),
		.mem_cmd_valid      (mem_cmd_valid),
		.mem_cmd_ready      (mem_cmd_ready),
		.mem_cmd_store      (mem_cmd_store),
		.mem_cmd_addr       (mem_cmd_addr),
		.mem_cmd_wdata      (mem_cmd_wdata),
		.mem_rsp_valid      (mem_rsp_valid),
		.mem_rsp_data       (mem_rsp_data),
		.mem_rsp_misaligned (mem_rsp_misaligned),
		.rqtype             (m_rqtype),
		.size               (m_size),
		.address            (m_address),
		.data               (m_data),
		.val                (m_val),
		.header_ack         (m_header_ack),
		.rsp_val            (m_rsp_val),
		.rsp_data           (l15_transducer_data_0),
		.rsp_returntype     (l15_transducer_returntype),
		.req_ack            (m_req_ack),
		.mem_pending        (mem_pending),
		.mem_done           (mem_done),
		.grant              (grant)
	);

endmodule

// ==== tb/l15_responder.sv ====
module l15_responder
(
	input  logic clk,
	input  logic nrst,
	input  logic [4:0] rqtype,
	input  logic [2:0] size,
	input  l15_pkg::addr_t address,
	input  l15_pkg::l15_word_t data,
	input  logic val,
	output logic header_ack,
	output logic rsp_val,
	output l15_pkg::l15_word_t rsp_data,
	output logic [3:0] returntype,
	input  logic req_ack
);
	import l15_pkg::*;

	word_t mem [0:4095];     // Byte address bits 13:2
	int error_count = 0;
	int data_req_count = 0;  // Requests into the data region
	int st;
	int cnt;
	logic [4:0] c_rqtype;
	addr_t c_address;
	l15_word_t c_data;

	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			st <= 0;
			header_ack <= 1'b0;
			rsp_val <= 1'b0;
			rsp_data <= '0;
			returntype <= '0;
		end
		else
		begin
			case (st)
				0:
				begin
					if (val)
					begin
						c_rqtype <= rqtype;
						c_address <= address;
						c_data <= data;
						cnt <= $urandom % 4;
						st <= 1;
						if (address[13])
							data_req_count <= data_req_count + 1;
						if (address[1:0] != 2'b00 || size != size_word)
						begin
							$display("Error at %0t: bad request address %h size %0d",
								$time, address, size);
							error_count <= error_count + 1;
						end
						if (!address[13] && rqtype != rqtype_load)
						begin
							$display("Error at %0t: non-load request in fetch region %h",
								$time, address);
							error_count <= error_count + 1;
						end
					end
				end
				1:
				begin
					// Fields must hold until the header ack is taken
					if (!val || rqtype != c_rqtype || address != c_address ||
						(c_rqtype == rqtype_store && data != c_data))
					begin
						$display("Error at %0t: request changed before header ack", $time);
						error_count <= error_count + 1;
					end
					if (cnt == 0)
					begin
						header_ack <= 1'b1;
						cnt <= $urandom % 4;
						st <= 2;
					end
					else
						cnt <= cnt - 1;
				end
				2:
				begin
					header_ack <= 1'b0;
					if (cnt == 0)
					begin
						rsp_val <= 1'b1;
						if (c_rqtype == rqtype_store)
						begin
							mem[c_address[13:2]] <= c_data.halves[c_address[2]];
							returntype <= rtype_store_ack;
							rsp_data <= '0;
						end
						else
						begin
							returntype <= rtype_load;
							rsp_data.halves[0] <= mem[{c_address[13:3], 1'b0}];
							rsp_data.halves[1] <= mem[{c_address[13:3], 1'b1}];
						end
						st <= 3;
					end
					else
						cnt <= cnt - 1;
				end
				default:
				begin
					// Only one request may be outstanding on the port
					if (val)
					begin
						$display("Error at %0t: new request while response outstanding",
							$time);
						error_count <= error_count + 1;
					end
					if (req_ack)
					begin
						rsp_val <= 1'b0;
						st <= 0;
					end
				end
			endcase
		end
	end

endmodule

// ==== tb/tb_core_mem_port.sv ====
module tb_core_mem_port;
	import l15_pkg::*;

	localparam addr_t start_pc = 32'h0000_0100;
	localparam int num_ops = 8 + 20 + 40 + 8;
	localparam int cycles_per_op = 60;

	logic clk;
	logic nrst;
	logic [4:0] rqtype;
	logic [2:0] size;
	addr_t address;
	logic [63:0] req_data;
	logic req_val;
	logic header_ack;
	logic rsp_val;
	logic [63:0] rsp_data;
	logic [3:0] returntype;
	logic req_ack;
	word_t instr;
	addr_t instr_pc;
	logic instr_valid;
	logic instr_ready;
	logic mem_cmd_valid;
	logic mem_cmd_ready;
	logic mem_cmd_store;
	addr_t mem_cmd_addr;
	word_t mem_cmd_wdata;
	logic mem_rsp_valid;
	word_t mem_rsp_data;
	logic mem_rsp_misaligned;

	word_t model_mem [0:4095];
	addr_t exp_pc = start_pc;
	int instr_count = 0;
	int fetch_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	core_mem_port #(.reset_pc(start_pc)) dut_i
	(
		.clk(clk), .nrst(nrst),
		.transducer_l15_rqtype(rqtype), .transducer_l15_size(size),
		.transducer_l15_address(address), .transducer_l15_data(req_data),
		.transducer_l15_val(req_val), .l15_transducer_header_ack(header_ack),
		.l15_transducer_val(rsp_val), .l15_transducer_data_0(rsp_data),
		.l15_transducer_returntype(returntype), .transducer_l15_req_ack(req_ack),
		.instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.mem_cmd_valid(mem_cmd_valid), .mem_cmd_ready(mem_cmd_ready),
		.mem_cmd_store(mem_cmd_store), .mem_cmd_addr(mem_cmd_addr),
		.mem_cmd_wdata(mem_cmd_wdata), .mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data), .mem_rsp_misaligned(mem_rsp_misaligned)
	);

	l15_responder l15_responder
	(
		.clk(clk), .nrst(nrst), .rqtype(rqtype), .size(size), .address(address),
		.data(req_data), .val(req_val), .header_ack(header_ack), .rsp_val(rsp_val),
		.rsp_data(rsp_data), .returntype(returntype), .req_ack(req_ack)
	);

	function automatic word_t fill_word(input addr_t a);
		return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp,
		inout int errs);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
			errs++;
		end
	endtask

	task automatic check_pc(input addr_t got, input addr_t exp, inout int errs);
		if (got !== exp)
		begin
			$display("Error at %0t: instr_pc got %h expected %h", $time, got, exp);
			errs++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp,
		inout int errs);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
			errs++;
		end
	endtask

	task automatic report(input string name, input int errors);
		if (errors == 0)
		begin
			tests_passed++;
			$display("Test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors);
		end
	endtask

	// One command through the memory port up to its response pulse
	task automatic mem_op(input logic store, input addr_t a, input word_t wd,
		output word_t rd, output logic mis);
		@(posedge clk);
		mem_cmd_valid <= 1'b1;
		mem_cmd_store <= store;
		mem_cmd_addr <= a;
		mem_cmd_wdata <= wd;
		do
			@(posedge clk);
		while (!mem_cmd_ready);
		mem_cmd_valid <= 1'b0;
		do
			@(posedge clk);
		while (!mem_rsp_valid);
		rd = mem_rsp_data;
		mis = mem_rsp_misaligned;
	endtask

	function automatic addr_t data_addr();
		return 32'h0000_2000 | (($urandom % 2048) << 2);
	endfunction

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Random back-pressure on the instruction output
	always @(posedge clk)
		instr_ready <= ($urandom % 4) != 0;

	// Fetch stream against the model
	always @(posedge clk)
	begin
		if (nrst && instr_valid && instr_ready)
		begin
			check_pc(instr_pc, exp_pc, fetch_errors);
			check_word("instr", instr, model_mem[exp_pc[13:2]], fetch_errors);
			exp_pc = exp_pc + 32'd4;
			instr_count++;
		end
	end

	initial
	begin
		#(num_ops * cycles_per_op * 40 + 400);
		$display("Timeout: the run did not finish in the expected time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		int errs;
		int snap;
		word_t rd;
		word_t wd;
		logic mis;
		addr_t a;
		void'($urandom(89));
		nrst = 1'b0;
		instr_ready = 1'b0;
		mem_cmd_valid = 1'b0;
		mem_cmd_store = 1'b0;
		mem_cmd_addr = '0;
		mem_cmd_wdata = '0;
		for (int i = 0; i < 4096; i++)
		begin
			model_mem[i] = fill_word(i * 4);
			l15_responder.mem[i] = fill_word(i * 4);
		end

		// Outputs during reset
		@(negedge clk);
		errs = 0;
		check_flag("transducer_l15_val", req_val, 1'b0, errs);
		check_flag("transducer_l15_req_ack", req_ack, 1'b0, errs);
		check_flag("instr_valid", instr_valid, 1'b0, errs);
		check_flag("mem_cmd_ready", mem_cmd_ready, 1'b0, errs);
		check_flag("mem_rsp_valid", mem_rsp_valid, 1'b0, errs);
		repeat (2)
			@(posedge clk);
		nrst <= 1'b1;
		report("reset", errs);

		errs = 0;
		for (int i = 0; i < 20; i++)
		begin
			a = data_addr();
			mem_op(1'b0, a, '0, rd, mis);
			check_word("load data", rd, model_mem[a[13:2]], errs);
			check_flag("misaligned", mis, 1'b0, errs);
		end
		report("random loads", errs);

		errs = 0;
		for (int i = 0; i < 20; i++)
		begin
			a = data_addr();
			wd = $urandom;
			mem_op(1'b1, a, wd, rd, mis);
			check_flag("store misaligned", mis, 1'b0, errs);
			model_mem[a[13:2]] = wd;
			mem_op(1'b0, a, '0, rd, mis);
			check_word("load after store", rd, model_mem[a[13:2]], errs);
		end
		report("store then load", errs);

		errs = 0;
		snap = l15_responder.data_req_count;
		for (int i = 0; i < 8; i++)
		begin
			a = data_addr() | (($urandom % 3) + 1);
			mem_op(1'(i % 2), a, $urandom, rd, mis);
			check_flag("misaligned", mis, 1'b1, errs);
		end
		repeat (10)
			@(posedge clk);
		if (l15_responder.data_req_count != snap)
		begin
			$display("Misaligned commands reached the L1.5 port");
			errs++;
		end
		report("misaligned", errs);

		if (instr_count < 16)
			$display("Fetch stream stalled after %0d instructions", instr_count);
		report("fetch stream", fetch_errors + int'(instr_count < 16));
		report("port protocol", l15_responder.error_count);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== src.f ====
logic/l15_pkg.sv
logic/l15_arbiter.sv
logic/l15_port_mux.sv
logic/fetch_unit.sv
logic/mem_unit.sv
logic/core_mem_port.sv
tb/l15_responder.sv
tb/tb_core_mem_port.sv

// ==== Makefile ====
SRCS := $(shell cat src.f)

obj_dir/Vtb_core_mem_port: src.f $(SRCS)
	verilator --binary --top-module tb_core_mem_port -f src.f -o Vtb_core_mem_port

.PHONY: run clean

run: obj_dir/Vtb_core_mem_port
	./obj_dir/Vtb_core_mem_port | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
